/* Makefile */
VERILATOR ?= verilator
TOP       := tb_decode_top
FILELIST  := compile.f
OBJ_DIR   := obj_dir
VFLAGS    := --binary --timing --assert -j 0
LINTFLAGS := --lint-only -Wall --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "RESULT: PASS"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

/* compile.f */
+incdir+.
rv_isa_pkg.sv
rv_ctrl_pkg.sv
inst_fetch.sv
inst_queue.sv
ctrl.sv
imm_gen.sv
inst_decode.sv
decode_top.sv
decode_checker.sv
tb_decode_top.sv

/* ctrl.sv */
`timescale 1ns/1ps

module ctrl (
    input  rv_isa_pkg::opcode_e opcode,
    input  logic [2:0]          funct3,
    input  logic [6:0]          funct7,
    output rv_ctrl_pkg::ctrl_t  ctrl_o
);

    rv_isa_pkg::alu_funct_e arith_funct;
    rv_isa_pkg::alu_funct_e imm_funct;
    rv_isa_pkg::alu_funct_e branch_funct;

    // Bit 30 only matters for shifts on the immediate path
    assign arith_funct = rv_isa_pkg::alu_funct_e'({1'b0, funct7[5], funct3});
    assign imm_funct   = (funct3 == 3'b101) ? arith_funct
                                            : rv_isa_pkg::alu_funct_e'({2'b00, funct3});

    always_comb begin
        case (funct3)
            3'b000:  branch_funct = rv_isa_pkg::EQ;
            3'b001:  branch_funct = rv_isa_pkg::NE;
            3'b100:  branch_funct = rv_isa_pkg::LT;
            3'b101:  branch_funct = rv_isa_pkg::GE;
            3'b110:  branch_funct = rv_isa_pkg::LTU;
            3'b111:  branch_funct = rv_isa_pkg::GEU;
            default: branch_funct = rv_isa_pkg::NO_FUNCT;
        endcase
    end

    always_comb begin
        ctrl_o           = '0;
        ctrl_o.alu_funct = rv_isa_pkg::NO_FUNCT;
        case (opcode)
            rv_isa_pkg::OP_LUI: begin
                ctrl_o.inst_type = rv_isa_pkg::FMT_U;
                ctrl_o.is_lui    = 1'b1;
            end
            rv_isa_pkg::OP_AUIPC: begin
                ctrl_o.inst_type = rv_isa_pkg::FMT_U;
                ctrl_o.is_auipc  = 1'b1;
            end
            rv_isa_pkg::OP_JAL: begin
                ctrl_o.inst_type = rv_isa_pkg::FMT_J;
                ctrl_o.is_jal    = 1'b1;
            end
            rv_isa_pkg::OP_JALR: begin
                ctrl_o.inst_type = rv_isa_pkg::FMT_I;
                ctrl_o.is_jalr   = 1'b1;
            end
            rv_isa_pkg::OP_BRANCH: begin
                ctrl_o.inst_type = rv_isa_pkg::FMT_B;
                ctrl_o.is_branch = 1'b1;
                ctrl_o.alu_funct = branch_funct;
            end
            rv_isa_pkg::OP_LOAD: begin
                ctrl_o.inst_type = rv_isa_pkg::FMT_I;
                ctrl_o.mem_r_en  = 1'b1;
                ctrl_o.alu_funct = rv_isa_pkg::ADD; // Address calculation
            end
            rv_isa_pkg::OP_STORE: begin
                ctrl_o.inst_type = rv_isa_pkg::FMT_S;
                ctrl_o.mem_w_en  = 1'b1;
                ctrl_o.alu_funct = rv_isa_pkg::ADD;
            end
            rv_isa_pkg::OP_IMM: begin
                ctrl_o.inst_type = rv_isa_pkg::FMT_I;
                ctrl_o.alu_funct = imm_funct;
            end
            rv_isa_pkg::OP_REG: begin
                ctrl_o.inst_type = rv_isa_pkg::FMT_R;
                ctrl_o.alu_funct = arith_funct;
            end
            rv_isa_pkg::OP_SYSTEM: ctrl_o.inst_type = rv_isa_pkg::FMT_I;
            default: begin
                ctrl_o.inst_type = rv_isa_pkg::FMT_NONE;
                ctrl_o.illegal   = 1'b1;
            end
        endcase

        ctrl_o.gpr_w_en     = ctrl_o.inst_type inside {rv_isa_pkg::FMT_R, rv_isa_pkg::FMT_I,
                                                       rv_isa_pkg::FMT_U, rv_isa_pkg::FMT_J};
        ctrl_o.alu_b_is_imm = ctrl_o.inst_type inside {rv_isa_pkg::FMT_I, rv_isa_pkg::FMT_S};

        // Byte, half, else full word
        case (funct3)
            3'b000:  ctrl_o.mem_mask = 4'b0001;
            3'b001:  ctrl_o.mem_mask = 4'b0011;
            default: ctrl_o.mem_mask = 4'b1111;
        endcase
    end

endmodule

/* decode_checker.sv */
`timescale 1ns/1ps

module decode_checker (
    input logic                  clk,
    input logic                  rst_n,
    input logic                  in_req,
    input logic                  in_ack,
    input logic                  out_req,
    input logic                  out_ack,
    input rv_ctrl_pkg::decoded_t out_dec
);

    // in_ack is seen high one edge after capture
    ack_after_req: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(in_ack) |-> $past(in_req))
        else $error("in_ack rose without a pending in_req");

    dec_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (out_req && $past(out_req)) |-> $stable(out_dec))
        else $error("out_dec changed while out_req was high");

    req_fall_after_ack: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(out_req) |-> $past(out_ack))
        else $error("out_req fell before out_ack was seen");

    idle_in_reset: assert property (@(posedge clk)
        !rst_n |-> (!in_ack && !out_req))
        else $error("handshake outputs active during reset");

endmodule

bind decode_top decode_checker u_checker (
    .clk     (clk),
    .rst_n   (rst_n),
    .in_req  (in_req),
    .in_ack  (in_ack),
    .out_req (out_req),
    .out_ack (out_ack),
    .out_dec (out_dec)
);

/* decode_top.sv */
`timescale 1ns/1ps
`include "rv_defines.svh"

module decode_top (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  in_req,
    input  logic [`RV_XLEN-1:0]   in_inst,
    output logic                  in_ack,
    output logic                  out_req,
    input  logic                  out_ack,
    output rv_ctrl_pkg::decoded_t out_dec
);

    logic                      push;
    rv_ctrl_pkg::fetch_entry_t push_entry;
    logic                      pop;
    rv_ctrl_pkg::fetch_entry_t head;
    logic                      empty;
    logic                      full;

    inst_fetch u_fetch (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_req     (in_req),
        .in_inst    (in_inst),
        .in_ack     (in_ack),
        .full       (full),
        .push       (push),
        .push_entry (push_entry)
    );

    inst_queue u_queue (
        .clk        (clk),
        .rst_n      (rst_n),
        .push       (push),
        .push_entry (push_entry),
        .pop        (pop),
        .head       (head),
        .empty      (empty),
        .full       (full)
    );

    inst_decode u_decode (
        .clk     (clk),
        .rst_n   (rst_n),
        .empty   (empty),
        .head    (head),
        .pop     (pop),
        .out_req (out_req),
        .out_ack (out_ack),
        .out_dec (out_dec)
    );

endmodule

/* imm_gen.sv */
`timescale 1ns/1ps
`include "rv_defines.svh"

module imm_gen (
    input  logic [`RV_XLEN-1:0]    inst,
    input  rv_isa_pkg::inst_type_e inst_type,
    output logic [`RV_XLEN-1:0]    imm
);

    logic sign;

    assign sign = inst[31];

    always_comb begin
        case (inst_type)
            rv_isa_pkg::FMT_I: begin
                imm = {{20{sign}}, inst[31:20]};
            end
            rv_isa_pkg::FMT_S: begin
                imm = {{20{sign}}, inst[31:25], inst[11:7]};
            end
            rv_isa_pkg::FMT_B: begin
                imm = {{19{sign}}, sign, inst[7], inst[30:25], inst[11:8], 1'b0};
            end
            rv_isa_pkg::FMT_U: begin
                imm = {inst[31:12], 12'b0}; // Upper 20 bits
            end
            rv_isa_pkg::FMT_J: begin
                imm = {{11{sign}}, sign, inst[19:12], inst[20], inst[30:21], 1'b0};
            end
            default: begin
                imm = '0; // R and NONE
            end
        endcase
    end

endmodule

/* inst_decode.sv */
`timescale 1ns/1ps
`include "rv_defines.svh"

module inst_decode (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      empty,
    input  rv_ctrl_pkg::fetch_entry_t head,
    output logic                      pop,
    output logic                      out_req,
    input  logic                      out_ack,
    output rv_ctrl_pkg::decoded_t     out_dec
);

    typedef enum logic [1:0] {
        DEC_IDLE,
        DEC_REQ,
        DEC_WAIT
    } dec_state_e;

    dec_state_e            state;
    rv_ctrl_pkg::ctrl_t    head_ctrl;
    logic [`RV_XLEN-1:0]   head_imm;
    rv_ctrl_pkg::decoded_t dec_next;

    ctrl u_ctrl (
        .opcode (rv_isa_pkg::opcode_e'(head.inst[`RV_F_OPCODE])),
        .funct3 (head.inst[`RV_F_FUNCT3]),
        .funct7 (head.inst[`RV_F_FUNCT7]),
        .ctrl_o (head_ctrl)
    );

    imm_gen u_imm_gen (
        .inst      (head.inst),
        .inst_type (head_ctrl.inst_type),
        .imm       (head_imm)
    );

    always_comb begin
        dec_next.pc   = head.pc;
        dec_next.ctrl = head_ctrl;
        dec_next.rd   = head.inst[`RV_F_RD];
        dec_next.rs1  = head.inst[`RV_F_RS1];
        dec_next.rs2  = head.inst[`RV_F_RS2];
        dec_next.imm  = head_imm;
    end

    assign pop     = (state == DEC_IDLE) && !empty;
    assign out_req = (state == DEC_REQ);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= DEC_IDLE;
        end else begin
            case (state)
                DEC_IDLE: if (!empty) state <= DEC_REQ;
                DEC_REQ:  if (out_ack) state <= DEC_WAIT;
                DEC_WAIT: if (!out_ack) state <= DEC_IDLE; // Sink released ack
                default:  state <= DEC_IDLE;
            endcase
        end
    end

    // Bundle held stable for the whole handshake
    always_ff @(posedge clk) begin
        if (pop) out_dec <= dec_next;
    end

endmodule

/* inst_fetch.sv */
`timescale 1ns/1ps
`include "rv_defines.svh"

module inst_fetch (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      in_req,
    input  logic [`RV_XLEN-1:0]       in_inst,
    output logic                      in_ack,
    input  logic                      full,
    output logic                      push,
    output rv_ctrl_pkg::fetch_entry_t push_entry
);

    typedef enum logic {
        ACK_IDLE,
        ACK_HIGH
    } ack_state_e;

    ack_state_e          state;
    logic [`RV_XLEN-1:0] pc;
    logic                capture;

    // One capture per handshake, held off while the queue is full
    assign capture = (state == ACK_IDLE) && in_req && !full;
    assign in_ack  = (state == ACK_HIGH);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= ACK_IDLE;
            pc    <= `RV_RESET_PC;
            push  <= 1'b0;
        end else begin
            push <= capture; // Written to the queue on the next edge
            case (state)
                ACK_IDLE: begin
                    if (capture) begin
                        state <= ACK_HIGH;
                        pc    <= pc + `RV_PC_STEP;
                    end
                end
                ACK_HIGH: begin
                    if (!in_req) state <= ACK_IDLE;
                end
                default: state <= ACK_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            push_entry.pc   <= pc;
            push_entry.inst <= in_inst;
        end
    end

endmodule

/* inst_queue.sv */
`timescale 1ns/1ps
`include "rv_defines.svh"

module inst_queue (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      push,
    input  rv_ctrl_pkg::fetch_entry_t push_entry,
    input  logic                      pop,
    output rv_ctrl_pkg::fetch_entry_t head,
    output logic                      empty,
    output logic                      full
);

    localparam int PTR_W = $clog2(`RV_IQ_DEPTH);
    localparam int CNT_W = $clog2(`RV_IQ_DEPTH + 1);

    rv_ctrl_pkg::fetch_entry_t mem [`RV_IQ_DEPTH];
    logic [PTR_W-1:0]          wr_ptr;
    logic [PTR_W-1:0]          rd_ptr;
    logic [CNT_W-1:0]          count;
    logic                      do_push;
    logic                      do_pop;

    assign do_push = push && !full;
    assign do_pop  = pop && !empty;
    assign empty   = (count == '0);
    assign full    = (count == CNT_W'(`RV_IQ_DEPTH));
    assign head    = mem[rd_ptr];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_W'(`RV_IQ_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(`RV_IQ_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count; // Both or neither
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) mem[wr_ptr] <= push_entry;
    end

endmodule

/* rv_ctrl_pkg.sv */
`include "rv_defines.svh"

package rv_ctrl_pkg;

    typedef struct packed {
        logic [`RV_XLEN-1:0] pc;
        logic [`RV_XLEN-1:0] inst;
    } fetch_entry_t;

    typedef struct packed {
        rv_isa_pkg::inst_type_e inst_type;
        logic                   is_branch;
        logic                   is_jal;
        logic                   is_jalr;
        logic                   gpr_w_en;
        logic                   alu_b_is_imm;
        rv_isa_pkg::alu_funct_e alu_funct;
        logic                   mem_r_en;
        logic                   mem_w_en;
        logic [3:0]             mem_mask; // Byte lanes
        logic                   is_lui;
        logic                   is_auipc;
        logic                   illegal;
    } ctrl_t;

    typedef struct packed {
        logic [`RV_XLEN-1:0] pc;
        ctrl_t               ctrl;
        logic [4:0]          rd;
        logic [4:0]          rs1;
        logic [4:0]          rs2;
        logic [`RV_XLEN-1:0] imm;
    } decoded_t;

endpackage

/* rv_defines.svh */
`ifndef RV_DEFINES_SVH
`define RV_DEFINES_SVH

// Datapath and queue sizing
`define RV_XLEN      32
`define RV_IQ_DEPTH  4

`define RV_RESET_PC  32'h0000_1000
`define RV_PC_STEP   32'd4

// Instruction field positions
`define RV_F_OPCODE  6:0
`define RV_F_RD      11:7
`define RV_F_FUNCT3  14:12
`define RV_F_RS1     19:15
`define RV_F_RS2     24:20
`define RV_F_FUNCT7  31:25

`endif

/* rv_isa_pkg.sv */
package rv_isa_pkg;

    typedef enum logic [6:0] {
        OP_LUI    = 7'b0110111,
        OP_AUIPC  = 7'b0010111,
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111,
        OP_BRANCH = 7'b1100011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_IMM    = 7'b0010011,
        OP_REG    = 7'b0110011,
        OP_SYSTEM = 7'b1110011
    } opcode_e;

    typedef enum logic [2:0] {
        FMT_R    = 3'd0,
        FMT_I    = 3'd1,
        FMT_S    = 3'd2,
        FMT_B    = 3'd3,
        FMT_U    = 3'd4,
        FMT_J    = 3'd5,
        FMT_NONE = 3'd6
    } inst_type_e;

    // Arithmetic codes are {1'b0, funct7[5], funct3}
    typedef enum logic [4:0] {
        ADD      = 5'b0_0000,
        SLL      = 5'b0_0001,
        SLT      = 5'b0_0010,
        SLTU     = 5'b0_0011,
        XOR      = 5'b0_0100,
        SRL      = 5'b0_0101,
        OR       = 5'b0_0110,
        AND      = 5'b0_0111,
        SUB      = 5'b0_1000,
        SRA      = 5'b0_1101,
        EQ       = 5'b1_0000, // Branch compares
        NE       = 5'b1_0001,
        LT       = 5'b1_0100,
        GE       = 5'b1_0101,
        LTU      = 5'b1_0110,
        GEU      = 5'b1_0111,
        NO_FUNCT = 5'b1_1111
    } alu_funct_e;

endpackage

/* tb_decode_top.sv */
`timescale 1ns/1ps
`include "rv_defines.svh"

module tb_decode_top;

    localparam int NUM_RANDOM = 200;
    localparam int MAX_CYCLES = NUM_RANDOM * 25; // Directed plus random, about 20 cycles each

    logic                  clk;
    logic                  rst_n;
    logic                  in_req;
    logic [`RV_XLEN-1:0]   in_inst;
    logic                  in_ack;
    logic                  out_req;
    logic                  out_ack;
    rv_ctrl_pkg::decoded_t out_dec;

    integer              seed;
    int                  cycles;
    logic                hold_ack;
    logic                full_seen;
    logic                ack_prev;
    logic                full_prev;
    logic [`RV_XLEN-1:0] next_pc;
    logic [`RV_XLEN-1:0] exp_inst_q [$];
    logic [`RV_XLEN-1:0] exp_pc_q [$];
    logic [6:0]          op_table [10];

    decode_top uut (
        .clk     (clk),
        .rst_n   (rst_n),
        .in_req  (in_req),
        .in_inst (in_inst),
        .in_ack  (in_ack),
        .out_req (out_req),
        .out_ack (out_ack),
        .out_dec (out_dec)
    );

    always #5 clk = ~clk;

    task automatic stop_with_failure(input string msg);
        $display("%s", msg);
        $display("RESULT: FAIL");
        $fatal(1, "Simulation stopped");
    endtask

    task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("[FAIL] t=%0t %s got 0x%08h expected 0x%08h", $time, name, got, exp);
            stop_with_failure("Value mismatch");
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    function automatic logic [31:0] make_inst(input logic [6:0] f7, input logic [4:0] rs2,
                                              input logic [4:0] rs1, input logic [2:0] f3,
                                              input logic [4:0] rd, input logic [6:0] op);
        return {f7, rs2, rs1, f3, rd, op};
    endfunction

    function automatic rv_ctrl_pkg::decoded_t ref_decode(input logic [31:0] inst,
                                                         input logic [31:0] pc);
        rv_ctrl_pkg::decoded_t d;
        logic [6:0]            op;
        logic [2:0]            f3;
        op  = inst[6:0];
        f3  = inst[14:12];
        d   = '0;
        d.pc  = pc;
        d.rd  = inst[11:7];
        d.rs1 = inst[19:15];
        d.rs2 = inst[24:20];
        d.ctrl.is_lui    = (op == 7'b0110111);
        d.ctrl.is_auipc  = (op == 7'b0010111);
        d.ctrl.is_jal    = (op == 7'b1101111);
        d.ctrl.is_jalr   = (op == 7'b1100111);
        d.ctrl.is_branch = (op == 7'b1100011);
        d.ctrl.mem_r_en  = (op == 7'b0000011);
        d.ctrl.mem_w_en  = (op == 7'b0100011);
        d.ctrl.mem_mask  = (f3 == 3'd0) ? 4'h1 : (f3 == 3'd1) ? 4'h3 : 4'hf;
        case (op)
            7'b0110111, 7'b0010111:                     d.ctrl.inst_type = rv_isa_pkg::FMT_U;
            7'b1101111:                                 d.ctrl.inst_type = rv_isa_pkg::FMT_J;
            7'b1100111, 7'b0000011, 7'b0010011, 7'b1110011: d.ctrl.inst_type = rv_isa_pkg::FMT_I;
            7'b1100011:                                 d.ctrl.inst_type = rv_isa_pkg::FMT_B;
            7'b0100011:                                 d.ctrl.inst_type = rv_isa_pkg::FMT_S;
            7'b0110011:                                 d.ctrl.inst_type = rv_isa_pkg::FMT_R;
            default:                                    d.ctrl.inst_type = rv_isa_pkg::FMT_NONE;
        endcase
        d.ctrl.illegal      = (d.ctrl.inst_type == rv_isa_pkg::FMT_NONE);
        d.ctrl.gpr_w_en     = !(d.ctrl.inst_type inside {rv_isa_pkg::FMT_S, rv_isa_pkg::FMT_B,
                                                         rv_isa_pkg::FMT_NONE});
        d.ctrl.alu_b_is_imm = (d.ctrl.inst_type == rv_isa_pkg::FMT_I) ||
                              (d.ctrl.inst_type == rv_isa_pkg::FMT_S);
        case (op)
            7'b1100011: begin
                case (f3)
                    3'd0:    d.ctrl.alu_funct = rv_isa_pkg::EQ;
                    3'd1:    d.ctrl.alu_funct = rv_isa_pkg::NE;
                    3'd4:    d.ctrl.alu_funct = rv_isa_pkg::LT;
                    3'd5:    d.ctrl.alu_funct = rv_isa_pkg::GE;
                    3'd6:    d.ctrl.alu_funct = rv_isa_pkg::LTU;
                    3'd7:    d.ctrl.alu_funct = rv_isa_pkg::GEU;
                    default: d.ctrl.alu_funct = rv_isa_pkg::NO_FUNCT;
                endcase
            end
            7'b0000011, 7'b0100011: d.ctrl.alu_funct = rv_isa_pkg::ADD;
            7'b0110011: d.ctrl.alu_funct = rv_isa_pkg::alu_funct_e'({1'b0, inst[30], f3});
            7'b0010011: begin // Bit 30 only counts for shifts right
                d.ctrl.alu_funct = rv_isa_pkg::alu_funct_e'({1'b0, (f3 == 3'b101) && inst[30], f3});
            end
            default: d.ctrl.alu_funct = rv_isa_pkg::NO_FUNCT;
        endcase
        case (d.ctrl.inst_type)
            rv_isa_pkg::FMT_I: d.imm = 32'($signed(inst[31:20]));
            rv_isa_pkg::FMT_S: d.imm = 32'($signed({inst[31:25], inst[11:7]}));
            rv_isa_pkg::FMT_B: begin
                d.imm = 32'($signed({inst[31], inst[7], inst[30:25], inst[11:8], 1'b0}));
            end
            rv_isa_pkg::FMT_U: d.imm = {inst[31:12], 12'h000};
            rv_isa_pkg::FMT_J: begin
                d.imm = 32'($signed({inst[31], inst[19:12], inst[20], inst[30:21], 1'b0}));
            end
            default: d.imm = '0;
        endcase
        return d;
    endfunction

    task automatic compare_bundle(input rv_ctrl_pkg::decoded_t got,
                                  input rv_ctrl_pkg::decoded_t exp);
        check_eq("pc", got.pc, exp.pc);
        check_eq("inst_type", 32'(got.ctrl.inst_type), 32'(exp.ctrl.inst_type));
        check_eq("is_branch", 32'(got.ctrl.is_branch), 32'(exp.ctrl.is_branch));
        check_eq("is_jal", 32'(got.ctrl.is_jal), 32'(exp.ctrl.is_jal));
        check_eq("is_jalr", 32'(got.ctrl.is_jalr), 32'(exp.ctrl.is_jalr));
        check_eq("gpr_w_en", 32'(got.ctrl.gpr_w_en), 32'(exp.ctrl.gpr_w_en));
        check_eq("alu_b_is_imm", 32'(got.ctrl.alu_b_is_imm), 32'(exp.ctrl.alu_b_is_imm));
        check_eq("alu_funct", 32'(got.ctrl.alu_funct), 32'(exp.ctrl.alu_funct));
        check_eq("mem_r_en", 32'(got.ctrl.mem_r_en), 32'(exp.ctrl.mem_r_en));
        check_eq("mem_w_en", 32'(got.ctrl.mem_w_en), 32'(exp.ctrl.mem_w_en));
        check_eq("mem_mask", 32'(got.ctrl.mem_mask), 32'(exp.ctrl.mem_mask));
        check_eq("is_lui", 32'(got.ctrl.is_lui), 32'(exp.ctrl.is_lui));
        check_eq("is_auipc", 32'(got.ctrl.is_auipc), 32'(exp.ctrl.is_auipc));
        check_eq("illegal", 32'(got.ctrl.illegal), 32'(exp.ctrl.illegal));
        check_eq("rd", 32'(got.rd), 32'(exp.rd));
        check_eq("rs1", 32'(got.rs1), 32'(exp.rs1));
        check_eq("rs2", 32'(got.rs2), 32'(exp.rs2));
        check_eq("imm", got.imm, exp.imm);
    endtask

    task automatic send_inst(input logic [31:0] word, input int gap);
        repeat (gap) next_cycle();
        exp_inst_q.push_back(word);
        exp_pc_q.push_back(next_pc);
        next_pc  = next_pc + `RV_PC_STEP;
        in_inst  = word;
        in_req   = 1'b1;
        do next_cycle(); while (!in_ack);
        in_req = 1'b0;
        do next_cycle(); while (in_ack);
    endtask

    task automatic wait_drained();
        while (exp_inst_q.size() != 0 || out_req || out_ack) next_cycle();
    endtask

    // Compare on each rise of out_req
    initial begin
        rv_ctrl_pkg::decoded_t expected;
        wait (rst_n === 1'b1);
        forever begin
            do next_cycle(); while (!out_req);
            if (exp_inst_q.size() == 0) begin
                stop_with_failure("out_req raised with no instruction outstanding");
            end
            expected = ref_decode(exp_inst_q.pop_front(), exp_pc_q.pop_front());
            compare_bundle(out_dec, expected);
            do next_cycle(); while (out_req);
        end
    end

    // Sink side of the output handshake
    initial begin
        int delay;
        wait (rst_n === 1'b1);
        forever begin
            do next_cycle(); while (!out_req);
            delay = {$random(seed)} % 6;
            repeat (delay) next_cycle();
            while (hold_ack) next_cycle(); // Back-pressure phase
            out_ack = 1'b1;
            do next_cycle(); while (out_req);
            out_ack = 1'b0;
        end
    end

    always @(negedge clk) begin
        if (rst_n) begin
            if (in_ack && !ack_prev && full_prev) begin
                stop_with_failure("in_ack rose while the queue was full");
            end
            if (uut.u_queue.full) full_seen = 1'b1;
            ack_prev  = in_ack;
            full_prev = uut.u_queue.full;
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= MAX_CYCLES) stop_with_failure("Timeout: run went past the cycle limit");
    end

    initial begin
        logic [31:0] r;
        logic [31:0] word;
        int          sel;
        seed      = 56;
        clk       = 1'b0;
        rst_n     = 1'b0;
        in_req    = 1'b0;
        in_inst   = '0;
        out_ack   = 1'b0;
        hold_ack  = 1'b0;
        full_seen = 1'b0;
        ack_prev  = 1'b0;
        full_prev = 1'b0;
        cycles    = 0;
        next_pc   = `RV_RESET_PC;
        op_table  = '{7'b0110111, 7'b0010111, 7'b1101111, 7'b1100111, 7'b1100011,
                      7'b0000011, 7'b0100011, 7'b0010011, 7'b0110011, 7'b1110011};
        repeat (8) @(posedge clk);
        #1 rst_n = 1'b1;

        send_inst(make_inst(7'h2a, 5'd5, 5'd6, 3'd1, 5'd7, 7'b0110111), 1);  // LUI
        send_inst(make_inst(7'h7f, 5'd0, 5'd31, 3'd7, 5'd8, 7'b0010111), 0); // AUIPC, negative
        send_inst(make_inst(7'h40, 5'd17, 5'd3, 3'd5, 5'd1, 7'b1101111), 2); // JAL backward
        send_inst(make_inst(7'h7f, 5'd30, 5'd2, 3'd0, 5'd1, 7'b1100111), 0); // JALR
        for (int f = 0; f < 8; f++) begin
            send_inst(make_inst(7'h41, 5'd9, 5'd10, 3'(f), 5'd11, 7'b1100011), 0);
            send_inst(make_inst(7'h7e, 5'd4, 5'd12, 3'(f), 5'd13, 7'b0000011), 1);
            send_inst(make_inst(7'h45, 5'd14, 5'd15, 3'(f), 5'd16, 7'b0100011), 0);
            send_inst(make_inst(7'h00, 5'd3, 5'd18, 3'(f), 5'd19, 7'b0010011), 0);
            send_inst(make_inst(7'h20, 5'd7, 5'd20, 3'(f), 5'd21, 7'b0010011), 2);
            send_inst(make_inst(7'h00, 5'd22, 5'd23, 3'(f), 5'd24, 7'b0110011), 0);
            send_inst(make_inst(7'h20, 5'd25, 5'd26, 3'(f), 5'd27, 7'b0110011), 1);
        end
        send_inst(make_inst(7'h00, 5'd0, 5'd0, 3'd0, 5'd0, 7'b1110011), 0);  // ECALL
        send_inst(make_inst(7'h13, 5'd1, 5'd2, 3'd3, 5'd4, 7'b1111111), 0);  // Unknown opcodes
        send_inst(make_inst(7'h55, 5'd5, 5'd6, 3'd0, 5'd7, 7'b0001011), 0);
        wait_drained();

        hold_ack = 1'b1;
        fork
            begin
                for (int i = 0; i < 7; i++) begin
                    send_inst(make_inst(7'h00, 5'(i), 5'(i + 1), 3'd0, 5'(i + 2), 7'b0010011), 0);
                end
            end
            begin
                repeat (40) next_cycle(); // Long enough to fill the queue
                hold_ack = 1'b0;
            end
        join
        wait_drained();
        check_eq("full_seen", 32'(full_seen), 32'd1);

        for (int i = 0; i < NUM_RANDOM; i++) begin
            r    = $random(seed);
            sel  = {$random(seed)} % 12;
            word = (sel < 10) ? {r[31:7], op_table[sel]} : r; // Some raw words too
            send_inst(word, {$random(seed)} % 4);
        end
        wait_drained();
        $display("RESULT: PASS");
        $finish;
    end

endmodule
